// ==== hanoi_game.f ====
+incdir+verif
hw/hanoi_pkg.sv
hw/display_pkg.sv
hw/peg_state.sv
hw/game_limits.sv
hw/board_painter.sv
hw/hanoi_top.sv
verif/hanoi_tb.sv

// ==== hw/board_painter.sv ====
module board_painter #(
	parameter int SLOT_CYCLES = 4
) (
	input  logic                   clk,
	input  logic                   reset,
	input  hanoi_pkg::disk_pegs_t  disk_pegs,
	output display_pkg::plot_t     pixel,
	output logic                   plot
);
	import hanoi_pkg::*;
	import display_pkg::*;

	localparam int CYC_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;
	localparam int SLOT_W = $clog2(NUM_SLOTS);

	logic [CYC_W-1:0]  cyc;
	logic [SLOT_W-1:0] slot;
	logic              slot_end;
	logic [1:0]        peg_idx;    // Peg number minus one
	disk_e             disk;
	peg_t              disk_peg;

	assign slot_end = (cyc == CYC_W'(SLOT_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (!reset) begin
			// Parked at the end of the last slot
			cyc <= CYC_W'(SLOT_CYCLES - 1);
			slot <= SLOT_W'(NUM_SLOTS - 1);
			plot <= 1'b0;
		end else begin
			plot <= slot_end;   // High while cyc is 0
			if (slot_end) begin
				cyc <= '0;
				slot <= (slot == SLOT_W'(NUM_SLOTS - 1)) ? '0 : slot + 1'b1;
			end else begin
				cyc <= cyc + 1'b1;
			end
		end
	end

	// Small disk first within each peg
	assign peg_idx = 2'(slot / NUM_DISKS);
	assign disk = disk_e'(slot % NUM_DISKS);

	always_comb begin
		case (disk)
			DISK_SMALL:  disk_peg = disk_pegs.small_disk;
			DISK_MEDIUM: disk_peg = disk_pegs.medium_disk;
			default:     disk_peg = disk_pegs.large_disk;
		endcase
	end

	assign pixel = '{
		x:      PEG_X[peg_idx],
		y:      DISK_Y[disk],
		colour: (disk_peg == peg_t'(peg_idx + 2'd1)) ? DISK_COLOUR[disk] : BLANK_COLOUR
	};

	if (SLOT_CYCLES > 1) begin : g_plot_check
		a_plot_single: assert property (@(posedge clk) disable iff (!reset)
			plot |=> !plot);
	end

endmodule

// ==== hw/display_pkg.sv ====
package display_pkg;

	// 160 by 120 screen
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;

	typedef logic [2:0] colour_t;   // RGB, one bit each

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
	} plot_t;

	// Indexed by peg number minus one
	localparam coord_x_t PEG_X [3] = '{8'd40, 8'd80, 8'd120};

	// Indexed by disk size, small first
	localparam coord_y_t DISK_Y [3] = '{7'd90, 7'd60, 7'd30};
	localparam colour_t DISK_COLOUR [3] = '{3'b100, 3'b010, 3'b001};

	localparam colour_t BLANK_COLOUR = 3'b000;

	// Three pegs by three disk sizes
	localparam int NUM_SLOTS = 9;

endpackage

// ==== hw/game_limits.sv ====
module game_limits #(
	parameter int TICK_DIV = 50_000_000,
	parameter int TIME_LIMIT = 60,
	parameter int STEP_LIMIT = 10
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               move_valid,
	input  logic               solved,
	output hanoi_pkg::count_t  time_left,
	output hanoi_pkg::count_t  steps_used,
	output logic               game_over
);
	import hanoi_pkg::*;

	localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic             running;

	assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));
	assign running = !game_over && !solved;

	// Free running tick divider
	always_ff @(posedge clk) begin
		if (!reset)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!reset)
			time_left <= count_t'(TIME_LIMIT);
		else if (tick && running)
			time_left <= time_left - 1'b1;   // Stops at 0 through game_over
	end

	// Every request counts, legal or not
	always_ff @(posedge clk) begin
		if (!reset)
			steps_used <= '0;
		else if (move_valid && running)
			steps_used <= steps_used + 1'b1;
	end

	assign game_over = (steps_used == count_t'(STEP_LIMIT)) || (time_left == '0);

	a_step_bound: assert property (@(posedge clk) disable iff (!reset)
		steps_used <= count_t'(STEP_LIMIT));

endmodule

// ==== hw/hanoi_pkg.sv ====
package hanoi_pkg;

	// Peg number, 0 means no peg
	typedef logic [1:0] peg_t;

	// Disk sizes, smallest first
	typedef enum logic [1:0] {
		DISK_SMALL,
		DISK_MEDIUM,
		DISK_LARGE
	} disk_e;

	localparam int NUM_DISKS = 3;

	// Peg that each disk sits on
	typedef struct packed {
		peg_t small_disk;
		peg_t medium_disk;
		peg_t large_disk;
	} disk_pegs_t;

	typedef struct packed {
		peg_t src;
		peg_t dst;
	} move_req_t;

	// Time left and steps used
	typedef logic [7:0] count_t;

	localparam peg_t START_PEG = 2'd1;

endpackage

// ==== hw/hanoi_top.sv ====
module hanoi_top #(
	parameter int TICK_DIV = 50_000_000,
	parameter int TIME_LIMIT = 60,
	parameter int STEP_LIMIT = 10,
	parameter int SLOT_CYCLES = 4
) (
	input  logic                   clk,
	input  logic                   reset,
	input  hanoi_pkg::move_req_t   move,
	input  logic                   move_valid,
	output hanoi_pkg::disk_pegs_t  disk_pegs,
	output logic                   solved,
	output logic                   game_over,
	output hanoi_pkg::count_t      time_left,
	output hanoi_pkg::count_t      steps_used,
	output display_pkg::plot_t     pixel,
	output logic                   plot
);

	// Board state and move checking
	peg_state u_peg_state (
		.clk        (clk),
		.reset      (reset),
		.move       (move),
		.move_valid (move_valid),
		.game_over  (game_over),
		.disk_pegs  (disk_pegs),
		.solved     (solved)
	);

	// Time and step limits
	game_limits #(
		.TICK_DIV   (TICK_DIV),
		.TIME_LIMIT (TIME_LIMIT),
		.STEP_LIMIT (STEP_LIMIT)
	) u_game_limits (
		.clk        (clk),
		.reset      (reset),
		.move_valid (move_valid),
		.solved     (solved),
		.time_left  (time_left),
		.steps_used (steps_used),
		.game_over  (game_over)
	);

	board_painter #(
		.SLOT_CYCLES (SLOT_CYCLES)
	) u_board_painter (
		.clk       (clk),
		.reset     (reset),
		.disk_pegs (disk_pegs),
		.pixel     (pixel),
		.plot      (plot)
	);

endmodule

// ==== hw/peg_state.sv ====
module peg_state (
	input  logic                   clk,
	input  logic                   reset,
	input  hanoi_pkg::move_req_t   move,
	input  logic                   move_valid,
	input  logic                   game_over,
	output hanoi_pkg::disk_pegs_t  disk_pegs,
	output logic                   solved
);
	import hanoi_pkg::*;

	peg_t       pos [NUM_DISKS];   // Peg of each disk, by size
	logic [1:0] top_rank [4];      // Smallest disk per peg, 0 when empty
	logic [1:0] src_rank;
	logic [1:0] dst_rank;
	logic       accept;
	logic       legal;

	assign pos[DISK_SMALL]  = disk_pegs.small_disk;
	assign pos[DISK_MEDIUM] = disk_pegs.medium_disk;
	assign pos[DISK_LARGE]  = disk_pegs.large_disk;

	// Walk from large to small so the smallest disk wins
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			top_rank[p] = 2'd0;
			for (int d = NUM_DISKS - 1; d >= 0; d--) begin
				if (pos[d] == peg_t'(p))
					top_rank[p] = 2'(d + 1);
			end
		end
	end

	assign src_rank = top_rank[move.src];
	assign dst_rank = top_rank[move.dst];

	assign accept = move_valid && !game_over && !solved;

	always_comb begin
		legal = (move.src != '0) && (move.dst != '0);
		legal = legal && (move.src != move.dst);
		legal = legal && (src_rank != 2'd0);   // Something to lift
		legal = legal && ((dst_rank == 2'd0) || (src_rank < dst_rank));
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			disk_pegs <= '{
				small_disk:  START_PEG,
				medium_disk: START_PEG,
				large_disk:  START_PEG
			};
		end else if (accept && legal) begin
			// Top disk of the source peg moves
			case (src_rank)
				2'd1:    disk_pegs.small_disk <= move.dst;
				2'd2:    disk_pegs.medium_disk <= move.dst;
				default: disk_pegs.large_disk <= move.dst;
			endcase
		end
	end

	// Whole stack on peg 2 or peg 3
	always_comb begin
		solved = (disk_pegs.small_disk == disk_pegs.medium_disk);
		solved = solved && (disk_pegs.medium_disk == disk_pegs.large_disk);
		solved = solved && (disk_pegs.large_disk == peg_t'(2)
			|| disk_pegs.large_disk == peg_t'(3));
	end

	a_no_peg_zero: assert property (@(posedge clk) disable iff (!reset)
		(disk_pegs.small_disk != '0) && (disk_pegs.medium_disk != '0)
		&& (disk_pegs.large_disk != '0));

	// Board only moves on a taken request
	a_stable_without_move: assert property (@(posedge clk) disable iff (!reset)
		!accept |=> $stable(disk_pegs));

endmodule

// ==== verif/hanoi_tests.svh ====
function automatic logic [31:0] next_random();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// Size index of the smallest disk on a peg, 3 when empty
function automatic int top_disk(input disk_pegs_t p, input peg_t peg);
	if (p.small_disk == peg)
		return 0;
	if (p.medium_disk == peg)
		return 1;
	if (p.large_disk == peg)
		return 2;
	return 3;
endfunction

function automatic disk_pegs_t apply_rule(input disk_pegs_t p, input move_req_t m);
	disk_pegs_t r;
	int         s_top;
	int         d_top;
	r = p;
	s_top = top_disk(p, m.src);
	d_top = top_disk(p, m.dst);
	if (m.src == '0 || m.dst == '0 || m.src == m.dst || s_top == 3)
		return r;
	if (d_top != 3 && d_top < s_top)
		return r;   // Larger disk onto a smaller one
	case (s_top)
		0: r.small_disk = m.dst;
		1: r.medium_disk = m.dst;
		default: r.large_disk = m.dst;
	endcase
	return r;
endfunction

function automatic logic is_solved(input disk_pegs_t p);
	return p.small_disk == p.medium_disk && p.medium_disk == p.large_disk
		&& (p.large_disk == peg_t'(2) || p.large_disk == peg_t'(3));
endfunction

function automatic plot_t expected_pixel(input disk_pegs_t p, input int slot);
	int    peg;
	int    size;
	peg_t  on;
	plot_t px;
	peg = slot / 3 + 1;
	size = slot % 3;
	case (size)
		0: on = p.small_disk;
		1: on = p.medium_disk;
		default: on = p.large_disk;
	endcase
	px.x = PEG_X[peg - 1];
	px.y = DISK_Y[size];
	px.colour = (on == peg_t'(peg)) ? DISK_COLOUR[size] : BLANK_COLOUR;
	return px;
endfunction

// Ends on the falling edge that releases reset
task automatic apply_reset();
	reset = 1'b0;
	move_valid = 1'b0;
	repeat (8) @(negedge clk);
	reset = 1'b1;
	model_pegs = '{small_disk: START_PEG, medium_disk: START_PEG, large_disk: START_PEG};
	model_steps = '0;
endtask

task automatic send_move(input move_req_t m);
	move = m;
	move_valid = 1'b1;
	@(negedge clk);
	move_valid = 1'b0;
endtask

task automatic model_apply(input move_req_t m);
	if (model_steps != count_t'(STEP_LIMIT) && !is_solved(model_pegs)) begin
		model_steps = model_steps + 1'b1;
		model_pegs = apply_rule(model_pegs, m);
	end
endtask

task automatic check_reset_state();
	apply_reset();
	check_pegs("reset_state pegs", model_pegs, disk_pegs);
	check_count("reset_state time", count_t'(TIME_LIMIT), time_left);
	check_count("reset_state steps", '0, steps_used);
	check_flag("reset_state solved", 1'b0, solved);
	check_flag("reset_state game_over", 1'b0, game_over);
	check_flag("reset_state plot", 1'b0, plot);
endtask

task automatic run_random_moves();
	move_req_t   m;
	logic [31:0] r;
	apply_reset();
	for (int i = 0; i < 9; i++) begin
		r = next_random();
		m = r[7:4];
		if (i == 2)
			m.src = '0;
		if (i == 5)
			m.dst = m.src;
		send_move(m);
		model_apply(m);
		check_pegs("random_moves pegs", model_pegs, disk_pegs);
		check_count("random_moves steps", model_steps, steps_used);
	end
endtask

task automatic solve_puzzle();
	move_req_t seq [7];
	count_t    held;
	seq = '{4'b01_11, 4'b01_10, 4'b11_10, 4'b01_11, 4'b10_01, 4'b10_11, 4'b01_11};
	apply_reset();
	foreach (seq[i]) begin
		check_flag("solve solved early", 1'b0, solved);
		send_move(seq[i]);
		model_apply(seq[i]);
		check_pegs("solve pegs", model_pegs, disk_pegs);
	end
	check_flag("solve solved", 1'b1, solved);
	send_move(4'b11_01);   // Ignored once solved
	model_apply(4'b11_01);
	check_pegs("solve frozen pegs", model_pegs, disk_pegs);
	check_count("solve frozen steps", 8'd7, steps_used);
	held = count_t'(TIME_LIMIT - release_edges / TICK_DIV);   // Ticks elapsed so far
	check_count("solve time at solve", held, time_left);
	repeat (3 * TICK_DIV) @(negedge clk);
	check_count("solve time held", held, time_left);
endtask

task automatic hit_step_limit();
	move_req_t bad [3];
	bad = '{4'b00_01, 4'b10_11, 4'b01_01};   // Zero peg, empty source, same peg
	apply_reset();
	for (int i = 0; i < STEP_LIMIT; i++) begin
		check_flag("step_limit game_over early", 1'b0, game_over);
		send_move(bad[i % 3]);
		model_apply(bad[i % 3]);
		check_pegs("step_limit pegs", model_pegs, disk_pegs);
		check_count("step_limit steps", model_steps, steps_used);
	end
	check_flag("step_limit game_over", 1'b1, game_over);
	send_move(4'b01_10);
	check_pegs("step_limit ignored move", model_pegs, disk_pegs);
	check_count("step_limit steps held", count_t'(STEP_LIMIT), steps_used);
endtask

task automatic run_out_of_time();
	count_t exp_time;
	apply_reset();
	for (int e = 1; e <= TIME_LIMIT * TICK_DIV; e++) begin
		@(negedge clk);
		exp_time = count_t'(TIME_LIMIT - release_edges / TICK_DIV);
		check_count("time_limit time", exp_time, time_left);
		check_flag("time_limit game_over", exp_time == '0, game_over);
	end
	send_move(4'b01_10);
	check_pegs("time_limit ignored move", model_pegs, disk_pegs);
	check_count("time_limit steps", '0, steps_used);
	repeat (TICK_DIV) @(negedge clk);
	check_count("time_limit time held", '0, time_left);
endtask

task automatic scan_painter();
	int   since;
	int   seen;
	logic exp_plot;
	seen = 0;
	apply_reset();
	send_move(4'b01_11);
	model_apply(4'b01_11);
	send_move(4'b01_10);
	model_apply(4'b01_10);
	for (int c = 0; c < 9 * SLOT_CYCLES; c++) begin
		if (c > 0)
			@(negedge clk);
		since = release_edges - 1;
		exp_plot = (since % SLOT_CYCLES == 0);
		if (plot === 1'b1)
			seen++;
		check_flag("painter plot", exp_plot, plot);
		if (exp_plot)
			check_pixel("painter pixel",
				expected_pixel(model_pegs, (since / SLOT_CYCLES) % NUM_SLOTS), pixel);
	end
	if (seen != NUM_SLOTS) begin
		other_errors++;
		$display("Painter gave %0d plot strobes in one full scan instead of %0d", seen, NUM_SLOTS);
	end
endtask

// ==== verif/hanoi_tb.sv ====
module hanoi_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import hanoi_pkg::*;
	import display_pkg::*;

	localparam int TICK_DIV = 20;
	localparam int TIME_LIMIT = 60;
	localparam int STEP_LIMIT = 10;
	localparam int SLOT_CYCLES = 4;
	// Two full countdowns plus the move tests
	localparam int MAX_CYCLES = 2 * TIME_LIMIT * TICK_DIV + 1600;

	logic       clk;
	logic       reset;
	move_req_t  move;
	logic       move_valid;
	disk_pegs_t disk_pegs;
	logic       solved;
	logic       game_over;
	count_t     time_left;
	count_t     steps_used;
	plot_t      pixel;
	logic       plot;

	int          value_errors;
	int          other_errors;
	int          cycle_count;
	int          release_edges;   // Rising edges since reset release
	logic [31:0] rng_state;
	disk_pegs_t  model_pegs;
	count_t      model_steps;

	hanoi_top #(
		.TICK_DIV    (TICK_DIV),
		.TIME_LIMIT  (TIME_LIMIT),
		.STEP_LIMIT  (STEP_LIMIT),
		.SLOT_CYCLES (SLOT_CYCLES)
	) dut (
		.clk        (clk),
		.reset      (reset),
		.move       (move),
		.move_valid (move_valid),
		.disk_pegs  (disk_pegs),
		.solved     (solved),
		.game_over  (game_over),
		.time_left  (time_left),
		.steps_used (steps_used),
		.pixel      (pixel),
		.plot       (plot)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!reset)
			release_edges <= 0;
		else
			release_edges <= release_edges + 1;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run stopped after %0d cycles before the tests finished", MAX_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	task automatic check_pegs(input string name, input disk_pegs_t exp, input disk_pegs_t act);
		if (act !== exp) begin
			value_errors++;
			$display("FAIL %s: expected s%0d m%0d l%0d actual s%0d m%0d l%0d", name,
				exp.small_disk, exp.medium_disk, exp.large_disk,
				act.small_disk, act.medium_disk, act.large_disk);
		end
	endtask

	task automatic check_count(input string name, input count_t exp, input count_t act);
		if (act !== exp) begin
			value_errors++;
			$display("FAIL %s: expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("FAIL %s: expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_pixel(input string name, input plot_t exp, input plot_t act);
		if (act !== exp) begin
			value_errors++;
			$display("FAIL %s: expected x%0d y%0d c%b actual x%0d y%0d c%b", name,
				exp.x, exp.y, exp.colour, act.x, act.y, act.colour);
		end
	endtask

	`include "hanoi_tests.svh"

	initial begin
		reset = 1'b0;
		move = '0;
		move_valid = 1'b0;
		value_errors = 0;
		other_errors = 0;
		rng_state = 32'd18;
		check_reset_state();
		run_random_moves();
		solve_puzzle();
		hit_step_limit();
		run_out_of_time();
		scan_painter();
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
